// ==== hw/adc_processing_pkg.sv ====
// Shared widths and types for the ADC post-processing datapath
// Imported by every stage and by the top level
`default_nettype none

package adc_processing_pkg;

    // Sample word and channel count limits
    parameter int DATA_WIDTH = 16;
    parameter int MAX_CHANNELS = 4;
    parameter int CHANNEL_WIDTH = $clog2(MAX_CHANNELS);

    // Signed ADC sample as seen on every stream
    typedef logic signed [DATA_WIDTH-1:0] sample_t;

    // Channel tag carried alongside each sample
    typedef logic [CHANNEL_WIDTH-1:0] channel_t;

    // Calibration gain as a right shift
    typedef logic [2:0] shift_t;

    // Decimation ratio where 0 and 1 both mean no decimation
    typedef logic [7:0] ratio_t;

    // Slow trip qualification time in clock cycles
    typedef logic [7:0] delay_t;

endpackage

`default_nettype wire

// ==== hw/calibration.sv ====
// Per-channel offset and gain correction for the incoming sample stream
// Offset add saturates to the sample range, gain is an arithmetic right shift
`timescale 1ns/1ps
`default_nettype none

module calibration #(
    parameter int N_CHANNELS = 4
) (
    input  wire                                                 clock,
    input  wire                                                 rst_n,
    input  wire adc_processing_pkg::sample_t                    in_data,
    input  wire adc_processing_pkg::channel_t                   in_channel,
    input  wire                                                 in_valid,
    input  wire adc_processing_pkg::sample_t [N_CHANNELS-1:0]   offsets,
    input  wire adc_processing_pkg::shift_t                     shift,
    output adc_processing_pkg::sample_t                         out_data,
    output adc_processing_pkg::channel_t                        out_channel,
    output logic                                                out_valid
);
    import adc_processing_pkg::*;

    sample_t                     offset_sel;
    logic signed [DATA_WIDTH:0]  sum;
    sample_t                     saturated;
    sample_t                     shifted;

    always_comb begin
        // Tags beyond the configured channels get no offset
        offset_sel = '0;
        if (int'(in_channel) < N_CHANNELS) begin
            offset_sel = offsets[in_channel];
        end
        // One guard bit so the sum cannot wrap
        sum = {in_data[DATA_WIDTH-1], in_data} + {offset_sel[DATA_WIDTH-1], offset_sel};
        // Top two bits differ only on overflow
        if (sum[DATA_WIDTH] != sum[DATA_WIDTH-1]) begin
            saturated = sum[DATA_WIDTH] ? {1'b1, {(DATA_WIDTH-1){1'b0}}}
                                        : {1'b0, {(DATA_WIDTH-1){1'b1}}};
        end else begin
            saturated = sum[DATA_WIDTH-1:0];
        end
        // Sign preserving gain
        shifted = saturated >>> shift;
    end

    // Strobe follows the input by exactly one cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            out_data    <= shifted;
            out_channel <= in_channel;
        end
    end

endmodule

`default_nettype wire

// ==== hw/comparator.sv ====
// Threshold detector with hysteresis or latching per channel
// Used once on the fast stream and once on the decimated stream
// Trip outputs are the OR over all channel flags
`timescale 1ns/1ps
`default_nettype none

module comparator #(
    parameter int N_CHANNELS = 4
) (
    input  wire                                clock,
    input  wire                                rst_n,
    input  wire adc_processing_pkg::sample_t   in_data,
    input  wire adc_processing_pkg::channel_t  in_channel,
    input  wire                                in_valid,
    input  wire adc_processing_pkg::sample_t   thr_low_fall,
    input  wire adc_processing_pkg::sample_t   thr_low_rise,
    input  wire adc_processing_pkg::sample_t   thr_high_fall,
    input  wire adc_processing_pkg::sample_t   thr_high_rise,
    input  wire                                latch_mode,
    input  wire                                clear_latch,
    output logic                               trip_high,
    output logic                               trip_low
);
    import adc_processing_pkg::*;

    // One high and one low flag for every channel
    logic [N_CHANNELS-1:0] high_flags;
    logic [N_CHANNELS-1:0] low_flags;
    logic [N_CHANNELS-1:0] high_next;
    logic [N_CHANNELS-1:0] low_next;
    logic                  chan_ok;

    always_comb begin
        chan_ok   = int'(in_channel) < N_CHANNELS;
        high_next = high_flags;
        low_next  = low_flags;
        if (latch_mode && clear_latch) begin
            // Clear wins over any sample arriving in the same cycle
            high_next = '0;
            low_next  = '0;
        end else if (in_valid && chan_ok) begin
            // High side, set above rise threshold
            if (in_data > thr_high_rise) begin
                high_next[in_channel] = 1'b1;
            end else if (!latch_mode && (in_data < thr_high_fall)) begin
                high_next[in_channel] = 1'b0;
            end
            // Low side mirrors the high side
            if (in_data < thr_low_fall) begin
                low_next[in_channel] = 1'b1;
            end else if (!latch_mode && (in_data > thr_low_rise)) begin
                low_next[in_channel] = 1'b0;
            end
        end
    end

    // Trips are registered from the next-state flags
    // so they move one cycle after the sample
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            high_flags <= '0;
            low_flags  <= '0;
            trip_high  <= 1'b0;
            trip_low   <= 1'b0;
        end else begin
            high_flags <= high_next;
            low_flags  <= low_next;
            trip_high  <= |high_next;
            trip_low   <= |low_next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/decimator.sv ====
// Per-channel decimator for an interleaved sample stream
// Forwards every ratio-th sample of each channel without averaging
`timescale 1ns/1ps
`default_nettype none

module decimator #(
    parameter int N_CHANNELS = 4
) (
    input  wire                                clock,
    input  wire                                rst_n,
    input  wire adc_processing_pkg::sample_t   in_data,
    input  wire adc_processing_pkg::channel_t  in_channel,
    input  wire                                in_valid,
    input  wire adc_processing_pkg::ratio_t    ratio,
    output adc_processing_pkg::sample_t        out_data,
    output adc_processing_pkg::channel_t       out_channel,
    output logic                               out_valid
);
    import adc_processing_pkg::*;

    // Samples seen since the last forwarded one, per channel
    ratio_t counters [N_CHANNELS];
    ratio_t count_sel;
    logic   chan_ok;
    logic   forward;

    always_comb begin
        chan_ok   = int'(in_channel) < N_CHANNELS;
        count_sel = '0;
        if (chan_ok) begin
            count_sel = counters[in_channel];
        end
        // Ratio 0 or 1 passes everything through
        forward = (ratio <= ratio_t'(1)) || (count_sel == ratio - ratio_t'(1));
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < N_CHANNELS; i++) begin
                counters[i] <= '0;
            end
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid && chan_ok && forward;
            if (in_valid && chan_ok) begin
                // Wrap to zero on the forwarded sample
                if (forward) begin
                    counters[in_channel] <= '0;
                end else begin
                    counters[in_channel] <= count_sel + ratio_t'(1);
                end
            end
        end
    end

    // Payload only loads on a forwarded sample
    always_ff @(posedge clock) begin
        if (in_valid && chan_ok && forward) begin
            out_data    <= in_data;
            out_channel <= in_channel;
        end
    end

endmodule

`default_nettype wire

// ==== hw/fault_combiner.sv ====
// Merges fast and slow comparator trips into a single fault line
// Fast trips fault at once, slow trips only after fault_delay cycles
// Optional sticky hold with clear, and a global disable
`timescale 1ns/1ps
`default_nettype none

module fault_combiner #(
    parameter bit STICKY_FAULT = 1'b1
) (
    input  wire                              clock,
    input  wire                              rst_n,
    input  wire                              fast_high,
    input  wire                              fast_low,
    input  wire                              slow_high,
    input  wire                              slow_low,
    input  wire adc_processing_pkg::delay_t  fault_delay,
    input  wire                              clear_fault,
    input  wire                              fault_disable,
    output logic                             fault
);
    import adc_processing_pkg::*;

    // Length of the current slow trip run without the present cycle
    delay_t       slow_count;
    logic         slow_any;
    logic         fast_any;
    logic [8:0]   run_len;
    logic         fault_cond;

    always_comb begin
        fast_any = fast_high | fast_low;
        slow_any = slow_high | slow_low;
        // Run length including the present cycle, one extra bit
        run_len  = {1'b0, slow_count} + 9'd1;
        fault_cond = fast_any || (slow_any && (run_len >= {1'b0, fault_delay}));
    end

    always_ff @(posedge clock) begin
        if (!rst_n || !slow_any) begin
            slow_count <= '0;
        end else if (slow_count != '1) begin
            // Saturate so long trips never wrap back under the delay
            slow_count <= slow_count + delay_t'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fault <= 1'b0;
        end else if (fault_disable) begin
            fault <= 1'b0;
        end else if (STICKY_FAULT) begin
            // Held until the host clears it
            if (clear_fault) begin
                fault <= 1'b0;
            end else if (fault_cond) begin
                fault <= 1'b1;
            end
        end else begin
            fault <= fault_cond;
        end
    end

endmodule

`default_nettype wire

// ==== hw/adc_processing.sv ====
// Top level of the ADC post-processing chain
// Calibration feeds the fast comparator and the decimator, decimator feeds
// the slow comparator, and both comparators drive the fault block
`timescale 1ns/1ps
`default_nettype none

module adc_processing #(
    parameter int N_CHANNELS   = 4,
    parameter bit STICKY_FAULT = 1'b1
) (
    input  wire                                                clock,
    input  wire                                                rst_n,
    // Raw interleaved samples
    input  wire adc_processing_pkg::sample_t                   in_data,
    input  wire adc_processing_pkg::channel_t                  in_channel,
    input  wire                                                in_valid,
    // Calibration setup
    input  wire adc_processing_pkg::sample_t [N_CHANNELS-1:0]  offsets,
    input  wire adc_processing_pkg::shift_t                    shift,
    // Fast comparator setup
    input  wire adc_processing_pkg::sample_t                   fast_thr_low_fall,
    input  wire adc_processing_pkg::sample_t                   fast_thr_low_rise,
    input  wire adc_processing_pkg::sample_t                   fast_thr_high_fall,
    input  wire adc_processing_pkg::sample_t                   fast_thr_high_rise,
    input  wire                                                fast_latch_mode,
    input  wire                                                fast_clear_latch,
    // Slow comparator setup
    input  wire adc_processing_pkg::sample_t                   slow_thr_low_fall,
    input  wire adc_processing_pkg::sample_t                   slow_thr_low_rise,
    input  wire adc_processing_pkg::sample_t                   slow_thr_high_fall,
    input  wire adc_processing_pkg::sample_t                   slow_thr_high_rise,
    input  wire                                                slow_latch_mode,
    input  wire                                                slow_clear_latch,
    // Decimation and fault setup
    input  wire adc_processing_pkg::ratio_t                    decimation_ratio,
    input  wire adc_processing_pkg::delay_t                    fault_delay,
    input  wire                                                clear_fault,
    input  wire                                                fault_disable,
    // Output streams and status
    output wire adc_processing_pkg::sample_t                   fast_data,
    output wire adc_processing_pkg::channel_t                  fast_channel,
    output wire                                                fast_valid,
    output wire adc_processing_pkg::sample_t                   filtered_data,
    output wire adc_processing_pkg::channel_t                  filtered_channel,
    output wire                                                filtered_valid,
    output wire                                                fast_trip_high,
    output wire                                                fast_trip_low,
    output wire                                                slow_trip_high,
    output wire                                                slow_trip_low,
    output wire                                                fault
);
    import adc_processing_pkg::*;

    // Calibrated stream, shared by both branches
    sample_t  cal_data;
    channel_t cal_channel;
    logic     cal_valid;

    // Decimated stream for the slow branch
    sample_t  dec_data;
    channel_t dec_channel;
    logic     dec_valid;

    calibration #(
        .N_CHANNELS(N_CHANNELS)
    ) calibrator (
        .clock(clock),
        .rst_n(rst_n),
        .in_data(in_data),
        .in_channel(in_channel),
        .in_valid(in_valid),
        .offsets(offsets),
        .shift(shift),
        .out_data(cal_data),
        .out_channel(cal_channel),
        .out_valid(cal_valid)
    );

    comparator #(
        .N_CHANNELS(N_CHANNELS)
    ) fast_cmp (
        .clock(clock),
        .rst_n(rst_n),
        .in_data(cal_data),
        .in_channel(cal_channel),
        .in_valid(cal_valid),
        .thr_low_fall(fast_thr_low_fall),
        .thr_low_rise(fast_thr_low_rise),
        .thr_high_fall(fast_thr_high_fall),
        .thr_high_rise(fast_thr_high_rise),
        .latch_mode(fast_latch_mode),
        .clear_latch(fast_clear_latch),
        .trip_high(fast_trip_high),
        .trip_low(fast_trip_low)
    );

    decimator #(
        .N_CHANNELS(N_CHANNELS)
    ) dec (
        .clock(clock),
        .rst_n(rst_n),
        .in_data(cal_data),
        .in_channel(cal_channel),
        .in_valid(cal_valid),
        .ratio(decimation_ratio),
        .out_data(dec_data),
        .out_channel(dec_channel),
        .out_valid(dec_valid)
    );

    comparator #(
        .N_CHANNELS(N_CHANNELS)
    ) slow_cmp (
        .clock(clock),
        .rst_n(rst_n),
        .in_data(dec_data),
        .in_channel(dec_channel),
        .in_valid(dec_valid),
        .thr_low_fall(slow_thr_low_fall),
        .thr_low_rise(slow_thr_low_rise),
        .thr_high_fall(slow_thr_high_fall),
        .thr_high_rise(slow_thr_high_rise),
        .latch_mode(slow_latch_mode),
        .clear_latch(slow_clear_latch),
        .trip_high(slow_trip_high),
        .trip_low(slow_trip_low)
    );

    fault_combiner #(
        .STICKY_FAULT(STICKY_FAULT)
    ) fault_unit (
        .clock(clock),
        .rst_n(rst_n),
        .fast_high(fast_trip_high),
        .fast_low(fast_trip_low),
        .slow_high(slow_trip_high),
        .slow_low(slow_trip_low),
        .fault_delay(fault_delay),
        .clear_fault(clear_fault),
        .fault_disable(fault_disable),
        .fault(fault)
    );

    // Both internal streams are also visible outside
    assign fast_data        = cal_data;
    assign fast_channel     = cal_channel;
    assign fast_valid       = cal_valid;
    assign filtered_data    = dec_data;
    assign filtered_channel = dec_channel;
    assign filtered_valid   = dec_valid;

endmodule

`default_nettype wire

// ==== verification/adc_processing_tb.sv ====
// Directed testbench for the ADC post-processing top level
// Covers calibration, decimation, both comparators and the fault block
// Built from list.f and prints the error counts and a final verdict
`timescale 1ns/1ps
`default_nettype none

module adc_processing_tb;
    import adc_processing_pkg::*;

    localparam int N_CHANNELS    = 4;
    localparam int FAST_TIMEOUT  = 20;
    localparam int DEC_TIMEOUT   = 200;
    localparam sample_t SAMPLE_MAX = sample_t'(2**(DATA_WIDTH-1) - 1);
    localparam sample_t SAMPLE_MIN = sample_t'(-(2**(DATA_WIDTH-1)));

    // Comparator thresholds and samples around them
    localparam sample_t THR_HIGH_RISE = sample_t'(1000);
    localparam sample_t THR_HIGH_FALL = sample_t'(500);
    localparam sample_t THR_LOW_FALL  = sample_t'(-1000);
    localparam sample_t THR_LOW_RISE  = sample_t'(-500);
    localparam sample_t ABOVE_HIGH    = sample_t'(1200);
    localparam sample_t BETWEEN_HIGH  = sample_t'(700);
    localparam sample_t BELOW_HIGH    = sample_t'(300);
    localparam sample_t BELOW_LOW     = sample_t'(-1200);
    localparam sample_t BETWEEN_LOW   = sample_t'(-700);
    localparam sample_t ABOVE_LOW     = sample_t'(-300);

    logic clock;
    logic rst_n;
    sample_t in_data;
    channel_t in_channel;
    logic in_valid;
    sample_t [N_CHANNELS-1:0] offsets;
    shift_t shift;
    sample_t fast_thr_low_fall;
    sample_t fast_thr_low_rise;
    sample_t fast_thr_high_fall;
    sample_t fast_thr_high_rise;
    logic fast_latch_mode;
    logic fast_clear_latch;
    sample_t slow_thr_low_fall;
    sample_t slow_thr_low_rise;
    sample_t slow_thr_high_fall;
    sample_t slow_thr_high_rise;
    logic slow_latch_mode;
    logic slow_clear_latch;
    ratio_t decimation_ratio;
    delay_t fault_delay;
    logic clear_fault;
    logic fault_disable;
    sample_t fast_data;
    channel_t fast_channel;
    logic fast_valid;
    sample_t filtered_data;
    channel_t filtered_channel;
    logic filtered_valid;
    logic fast_trip_high;
    logic fast_trip_low;
    logic slow_trip_high;
    logic slow_trip_low;
    logic fault;

    int error_count;
    int timeout_count;

    // Filtered samples seen by the monitor
    sample_t  filt_data_q[$];
    channel_t filt_chan_q[$];

    adc_processing #(
        .N_CHANNELS(N_CHANNELS),
        .STICKY_FAULT(1'b1)
    ) dut (
        .clock(clock),
        .rst_n(rst_n),
        .in_data(in_data),
        .in_channel(in_channel),
        .in_valid(in_valid),
        .offsets(offsets),
        .shift(shift),
        .fast_thr_low_fall(fast_thr_low_fall),
        .fast_thr_low_rise(fast_thr_low_rise),
        .fast_thr_high_fall(fast_thr_high_fall),
        .fast_thr_high_rise(fast_thr_high_rise),
        .fast_latch_mode(fast_latch_mode),
        .fast_clear_latch(fast_clear_latch),
        .slow_thr_low_fall(slow_thr_low_fall),
        .slow_thr_low_rise(slow_thr_low_rise),
        .slow_thr_high_fall(slow_thr_high_fall),
        .slow_thr_high_rise(slow_thr_high_rise),
        .slow_latch_mode(slow_latch_mode),
        .slow_clear_latch(slow_clear_latch),
        .decimation_ratio(decimation_ratio),
        .fault_delay(fault_delay),
        .clear_fault(clear_fault),
        .fault_disable(fault_disable),
        .fast_data(fast_data),
        .fast_channel(fast_channel),
        .fast_valid(fast_valid),
        .filtered_data(filtered_data),
        .filtered_channel(filtered_channel),
        .filtered_valid(filtered_valid),
        .fast_trip_high(fast_trip_high),
        .fast_trip_low(fast_trip_low),
        .slow_trip_high(slow_trip_high),
        .slow_trip_low(slow_trip_low),
        .fault(fault)
    );

    // 40 ns period
    always #20 clock = ~clock;

    // Outputs are stable at the falling edge
    always @(negedge clock) begin
        if (filtered_valid) begin
            filt_data_q.push_back(filtered_data);
            filt_chan_q.push_back(filtered_channel);
        end
    end

    // Offset add, clamp to the sample range, then arithmetic shift
    function automatic sample_t calibrated_value(sample_t raw, sample_t off, shift_t sh);
        int sum;
        sum = int'(raw) + int'(off);
        if (sum > int'(SAMPLE_MAX)) begin
            sum = int'(SAMPLE_MAX);
        end else if (sum < int'(SAMPLE_MIN)) begin
            sum = int'(SAMPLE_MIN);
        end
        sum = sum >>> sh;
        return sample_t'(sum);
    endfunction

    task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_channel(input string name, input channel_t expected,
                                 input channel_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            error_count++;
        end
    endtask

    // Each step lands 2 ns after a rising edge
    task automatic advance_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #2;
        end
    endtask

    task automatic reset_dut;
        rst_n = 1'b0;
        advance_cycles(2);
        rst_n = 1'b1;
    endtask

    // Holds valid for one cycle
    // Back-to-back calls keep valid high
    task automatic pulse_sample(input sample_t data, input channel_t chan);
        in_data    = data;
        in_channel = chan;
        in_valid   = 1'b1;
        advance_cycles(1);
        in_valid   = 1'b0;
    endtask

    task automatic set_fast_thresholds(input sample_t lf, input sample_t lr,
                                       input sample_t hf, input sample_t hr);
        fast_thr_low_fall  = lf;
        fast_thr_low_rise  = lr;
        fast_thr_high_fall = hf;
        fast_thr_high_rise = hr;
    endtask

    task automatic set_slow_thresholds(input sample_t lf, input sample_t lr,
                                       input sample_t hf, input sample_t hr);
        slow_thr_low_fall  = lf;
        slow_thr_low_rise  = lr;
        slow_thr_high_fall = hf;
        slow_thr_high_rise = hr;
    endtask

    task automatic init_inputs;
        clock            = 1'b0;
        rst_n            = 1'b0;
        in_data          = '0;
        in_channel       = '0;
        in_valid         = 1'b0;
        offsets          = '0;
        shift            = '0;
        fast_latch_mode  = 1'b0;
        fast_clear_latch = 1'b0;
        slow_latch_mode  = 1'b0;
        slow_clear_latch = 1'b0;
        decimation_ratio = ratio_t'(1);
        fault_delay      = delay_t'(4);
        clear_fault      = 1'b0;
        fault_disable    = 1'b0;
        // Wide open so nothing trips
        set_fast_thresholds(SAMPLE_MIN, SAMPLE_MIN, SAMPLE_MAX, SAMPLE_MAX);
        set_slow_thresholds(SAMPLE_MIN, SAMPLE_MIN, SAMPLE_MAX, SAMPLE_MAX);
    endtask

    // Send one sample and compare the fast stream result
    task automatic calibrate_one(input sample_t raw, input channel_t chan);
        sample_t expected;
        int latency;
        expected = calibrated_value(raw, offsets[chan], shift);
        pulse_sample(raw, chan);
        latency = 1;
        while (!fast_valid && latency <= FAST_TIMEOUT) begin
            advance_cycles(1);
            latency++;
        end
        if (!fast_valid) begin
            $display("ERROR calibration: fast_valid never came after an input sample");
            timeout_count++;
        end else begin
            if (latency != 1) begin
                $display("FAILED calibration latency: expected 1, actual %0d", latency);
                error_count++;
            end
            check_sample("calibration data", expected, fast_data);
            check_channel("calibration channel", chan, fast_channel);
        end
    endtask

    task automatic sweep_calibration;
        reset_dut();
        // Positive and negative saturation
        offsets[0] = sample_t'(1000);
        offsets[1] = sample_t'(-1000);
        shift = shift_t'(0);
        calibrate_one(sample_t'(32000), channel_t'(0));
        calibrate_one(sample_t'(-32000), channel_t'(1));
        shift = shift_t'(2);
        calibrate_one(sample_t'(32000), channel_t'(0));
        calibrate_one(sample_t'(-32000), channel_t'(1));
        for (int c = 0; c < N_CHANNELS; c++) begin
            offsets[c] = sample_t'($urandom);
        end
        for (int i = 0; i < 40; i++) begin
            shift = shift_t'($urandom);
            calibrate_one(sample_t'($urandom), channel_t'($urandom));
        end
        offsets = '0;
        shift = '0;
    endtask

    // Interleave all channels and compare every forwarded sample in order
    task automatic decimate_run(input ratio_t ratio, input int rounds);
        sample_t  exp_data_q[$];
        channel_t exp_chan_q[$];
        sample_t  raw;
        string    name;
        int       cycles;
        int       n;
        name = $sformatf("decimation ratio %0d", ratio);
        reset_dut();
        decimation_ratio = ratio;
        filt_data_q.delete();
        filt_chan_q.delete();
        for (int r = 0; r < rounds; r++) begin
            for (int c = 0; c < N_CHANNELS; c++) begin
                raw = sample_t'($urandom);
                // ratio-th, 2*ratio-th, ... sample of each channel
                if (ratio <= ratio_t'(1) || ((r + 1) % int'(ratio)) == 0) begin
                    exp_data_q.push_back(calibrated_value(raw, offsets[c], shift));
                    exp_chan_q.push_back(channel_t'(c));
                end
                pulse_sample(raw, channel_t'(c));
            end
        end
        cycles = 0;
        while (filt_data_q.size() < exp_data_q.size() && cycles < DEC_TIMEOUT) begin
            advance_cycles(1);
            cycles++;
        end
        if (filt_data_q.size() < exp_data_q.size()) begin
            $display("ERROR %s: filtered_valid never came for all expected samples", name);
            timeout_count++;
        end
        // Catch any extra forwarded sample
        advance_cycles(4);
        if (filt_data_q.size() != exp_data_q.size()) begin
            $display("FAILED %s count: expected %0d, actual %0d", name, exp_data_q.size(),
                     filt_data_q.size());
            error_count++;
        end
        n = (filt_data_q.size() < exp_data_q.size()) ? filt_data_q.size() : exp_data_q.size();
        for (int i = 0; i < n; i++) begin
            check_sample(name, exp_data_q[i], filt_data_q[i]);
            check_channel(name, exp_chan_q[i], filt_chan_q[i]);
        end
    endtask

    task automatic decimate_ratios;
        decimate_run(ratio_t'(3), 9);
        decimate_run(ratio_t'(1), 3);
    endtask

    // Trip moves 2 cycles after the input sample
    task automatic fast_hysteresis_steps;
        reset_dut();
        set_fast_thresholds(THR_LOW_FALL, THR_LOW_RISE, THR_HIGH_FALL, THR_HIGH_RISE);
        pulse_sample(ABOVE_HIGH, channel_t'(1));
        check_flag("fast high before update", 1'b0, fast_trip_high);
        advance_cycles(1);
        check_flag("fast high above rise", 1'b1, fast_trip_high);
        pulse_sample(BETWEEN_HIGH, channel_t'(1));
        advance_cycles(1);
        check_flag("fast high between thresholds", 1'b1, fast_trip_high);
        pulse_sample(BELOW_HIGH, channel_t'(1));
        advance_cycles(1);
        check_flag("fast high below fall", 1'b0, fast_trip_high);
        pulse_sample(BELOW_LOW, channel_t'(1));
        check_flag("fast low before update", 1'b0, fast_trip_low);
        advance_cycles(1);
        check_flag("fast low below fall", 1'b1, fast_trip_low);
        pulse_sample(BETWEEN_LOW, channel_t'(1));
        advance_cycles(1);
        check_flag("fast low between thresholds", 1'b1, fast_trip_low);
        pulse_sample(ABOVE_LOW, channel_t'(1));
        advance_cycles(1);
        check_flag("fast low above rise", 1'b0, fast_trip_low);
        set_fast_thresholds(SAMPLE_MIN, SAMPLE_MIN, SAMPLE_MAX, SAMPLE_MAX);
    endtask

    // Slow trip moves 3 cycles after the input at ratio 1
    task automatic slow_latch_hold;
        reset_dut();
        decimation_ratio = ratio_t'(1);
        slow_latch_mode = 1'b1;
        set_slow_thresholds(THR_LOW_FALL, THR_LOW_RISE, SAMPLE_MAX, SAMPLE_MAX);
        pulse_sample(BELOW_LOW, channel_t'(2));
        advance_cycles(1);
        check_flag("slow low before update", 1'b0, slow_trip_low);
        advance_cycles(1);
        check_flag("slow low set", 1'b1, slow_trip_low);
        pulse_sample(ABOVE_LOW, channel_t'(2));
        advance_cycles(3);
        check_flag("slow low held by latch", 1'b1, slow_trip_low);
        slow_clear_latch = 1'b1;
        advance_cycles(1);
        slow_clear_latch = 1'b0;
        check_flag("slow low after clear", 1'b0, slow_trip_low);
        advance_cycles(1);
        check_flag("slow low stays clear", 1'b0, slow_trip_low);
        slow_latch_mode = 1'b0;
        set_slow_thresholds(SAMPLE_MIN, SAMPLE_MIN, SAMPLE_MAX, SAMPLE_MAX);
    endtask

    // Slow trip held for a given number of cycles on channel 3
    task automatic slow_fault_case(input int hold, input logic expected, input string name);
        reset_dut();
        decimation_ratio = ratio_t'(1);
        fault_delay = delay_t'(4);
        set_slow_thresholds(SAMPLE_MIN, SAMPLE_MIN, THR_HIGH_FALL, THR_HIGH_RISE);
        pulse_sample(ABOVE_HIGH, channel_t'(3));
        advance_cycles(hold - 1);
        check_flag({name, " slow trip high"}, 1'b1, slow_trip_high);
        pulse_sample(BELOW_HIGH, channel_t'(3));
        advance_cycles(4);
        check_flag({name, " slow trip cleared"}, 1'b0, slow_trip_high);
        check_flag(name, expected, fault);
        set_slow_thresholds(SAMPLE_MIN, SAMPLE_MIN, SAMPLE_MAX, SAMPLE_MAX);
    endtask

    task automatic fault_sequence;
        reset_dut();
        set_fast_thresholds(THR_LOW_FALL, THR_LOW_RISE, THR_HIGH_FALL, THR_HIGH_RISE);
        pulse_sample(ABOVE_HIGH, channel_t'(0));
        advance_cycles(1);
        check_flag("fault before fast trip registers", 1'b0, fault);
        advance_cycles(1);
        check_flag("fault from fast trip", 1'b1, fault);
        pulse_sample(BELOW_HIGH, channel_t'(0));
        advance_cycles(3);
        check_flag("fast trip cleared", 1'b0, fast_trip_high);
        check_flag("fault sticky", 1'b1, fault);
        clear_fault = 1'b1;
        advance_cycles(1);
        clear_fault = 1'b0;
        check_flag("fault after clear", 1'b0, fault);
        // Disable masks a live fast trip
        fault_disable = 1'b1;
        pulse_sample(ABOVE_HIGH, channel_t'(0));
        advance_cycles(3);
        check_flag("fast trip while disabled", 1'b1, fast_trip_high);
        check_flag("fault disabled", 1'b0, fault);
        pulse_sample(BELOW_HIGH, channel_t'(0));
        advance_cycles(3);
        fault_disable = 1'b0;
        advance_cycles(1);
        check_flag("fault after disable drops", 1'b0, fault);
        set_fast_thresholds(SAMPLE_MIN, SAMPLE_MIN, SAMPLE_MAX, SAMPLE_MAX);
        slow_fault_case(4, 1'b1, "slow trip held fault_delay cycles");
        slow_fault_case(3, 1'b0, "slow trip held too briefly");
    endtask

    initial begin
        error_count = 0;
        timeout_count = 0;
        void'($urandom(77055));
        init_inputs();
        sweep_calibration();
        decimate_ratios();
        fast_hysteresis_steps();
        slow_latch_hold();
        fault_sequence();
        $display("Errors: %0d wrong values, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/adc_processing_pkg.sv
hw/calibration.sv
hw/comparator.sv
hw/decimator.sv
hw/fault_combiner.sv
hw/adc_processing.sv
verification/adc_processing_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ADC post-processing testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f list.f --top-module adc_processing_tb -o adc_processing_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/adc_processing_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation run returned status $run_status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
exit 1
